/* logic/cpc_io_pkg.sv */
package cpc_io_pkg;

  // ==================================================
  // Bus and register widths
  // ==================================================
  typedef logic [15:0] addr_t;       // CPU address bus
  typedef logic [7:0]  byte_t;       // CPU data byte
  typedef logic [3:0]  pen_t;        // Palette index
  typedef logic [4:0]  color_t;      // Hardware colour number
  typedef logic [9:0]  scr_start_t;  // CRTC screen start, R12/R13
  typedef logic [4:0]  crtc_idx_t;   // CRTC register index

  // ==================================================
  // Register command targets
  // ==================================================
  // One value per register group a write can reach
  typedef enum logic [3:0] {
    ga_pen_sel,    // GA function 0, pen / border select
    ga_color,      // GA function 1, colour for selected pen
    ga_rom_mode,   // GA function 2, mode and ROM disables
    ga_ram_cfg,    // GA function 3, RAM banking
    rom_bank_sel,  // Upper ROM select
    ppi_a_wr,      // PPI port A latch
    ppi_c_wr,      // PPI port C latch
    crtc_index,    // CRTC register select
    crtc_data      // CRTC register data
  } cmd_target_e;

  // ==================================================
  // I/O address decode
  // ==================================================
  // Gate array responds on A15:A14 = 01
  localparam logic [1:0] GA_PAGE = 2'b01;

  // Full upper-byte pages
  localparam byte_t PPI_A_PAGE     = 8'hf4;
  localparam byte_t PPI_C_PAGE     = 8'hf6;
  localparam byte_t CRTC_SEL_PAGE  = 8'hbc;
  localparam byte_t CRTC_DATA_PAGE = 8'hbd;

  // CRTC start address registers
  localparam crtc_idx_t CRTC_REG_START_HI = 5'd12;  // Bits 9:8 of start
  localparam crtc_idx_t CRTC_REG_START_LO = 5'd13;  // Bits 7:0 of start

  // ==================================================
  // Command FIFO and palette sizing
  // ==================================================
  localparam int CMD_FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W     = $clog2(CMD_FIFO_DEPTH);

  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;  // Read / write pointer
  typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;  // Occupancy, 0..depth

  localparam int NUM_PENS = 16;  // Ink palette entries

endpackage

/* logic/io_cmd_if.sv */
// One decoded register write moving between blocks
interface io_cmd_if import cpc_io_pkg::*; ();

  logic        cmd_valid;   // Command present
  cmd_target_e cmd_target;  // Which register group
  byte_t       cmd_data;    // Write data of the cycle
  logic        cmd_border;  // Address bit 4, GA border select
  logic        cmd_ready;   // Receiver takes it this edge

  // Sending side
  modport src (
    output cmd_valid,
    output cmd_target,
    output cmd_data,
    output cmd_border,
    input  cmd_ready
  );

  // Receiving side
  modport dst (
    input  cmd_valid,
    input  cmd_target,
    input  cmd_data,
    input  cmd_border,
    output cmd_ready
  );

endinterface

/* logic/io_write_decoder.sv */
// Turns CPU I/O write cycles into register commands
// Purely combinational, no state
module io_write_decoder import cpc_io_pkg::*; (
  input  logic  i_bus_valid,  // Write cycle on the bus
  output logic  o_bus_ready,  // Cycle taken this edge
  input  addr_t i_addr,
  input  byte_t i_wdata,
  io_cmd_if.src cmd
);

  logic        ga_cs;        // Gate array page
  logic        rom_bank_cs;  // Upper ROM select, A13 low
  byte_t       page;         // Upper address byte
  logic        hit;          // Some decode matched
  cmd_target_e target;

  // ==================================================
  // Chip selects
  // ==================================================
  assign ga_cs       = (i_addr[15:14] == GA_PAGE);
  assign rom_bank_cs = ~i_addr[13];
  assign page        = i_addr[15:8];

  // ==================================================
  // Target select
  // ==================================================
  // Gate array first, then ROM select, then full pages
  always_comb begin
    hit    = 1'b1;
    target = ga_pen_sel;
    if (ga_cs) begin
      // Function number in data bits 7:6
      case (i_wdata[7:6])
        2'd0:    target = ga_pen_sel;
        2'd1:    target = ga_color;
        2'd2:    target = ga_rom_mode;
        default: target = ga_ram_cfg;
      endcase
    end else if (rom_bank_cs) begin
      target = rom_bank_sel;
    end else if (page == PPI_A_PAGE) begin
      target = ppi_a_wr;
    end else if (page == PPI_C_PAGE) begin
      target = ppi_c_wr;  // Also carries PSG bus control
    end else if (page == CRTC_SEL_PAGE) begin
      target = crtc_index;
    end else if (page == CRTC_DATA_PAGE) begin
      target = crtc_data;
    end else begin
      // Nothing here, cycle is swallowed
      hit = 1'b0;
    end
  end

  // ==================================================
  // Command side
  // ==================================================
  // Unmatched cycles still wait for ready, then vanish
  assign cmd.cmd_valid  = i_bus_valid & hit;
  assign cmd.cmd_target = target;
  assign cmd.cmd_data   = i_wdata;
  assign cmd.cmd_border = i_addr[4];  // Only meaningful for GA fn 0

  // Bus stalls whenever the queue is full
  assign o_bus_ready = cmd.cmd_ready;

endmodule

/* logic/io_cmd_fifo.sv */
// Small circular queue of register commands
// Push and pop allowed on the same edge
module io_cmd_fifo import cpc_io_pkg::*; (
  input  logic  clk_cpu,
  input  logic  pwr_up_reset_n,
  io_cmd_if.dst wr_side,  // From decoder
  io_cmd_if.src rd_side,  // To register block
  output logic  o_full
);

  // Entry storage
  cmd_target_e tgt_mem    [CMD_FIFO_DEPTH];
  byte_t       data_mem   [CMD_FIFO_DEPTH];
  logic        border_mem [CMD_FIFO_DEPTH];

  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_cnt_t count;
  logic      push;
  logic      pop;

  // ==================================================
  // Handshakes
  // ==================================================
  assign o_full            = (count == fifo_cnt_t'(CMD_FIFO_DEPTH));
  assign wr_side.cmd_ready = ~o_full;
  assign push              = wr_side.cmd_valid & wr_side.cmd_ready;
  assign pop               = rd_side.cmd_valid & rd_side.cmd_ready;

  // Head of queue straight out of the array
  assign rd_side.cmd_valid  = (count != '0);
  assign rd_side.cmd_target = tgt_mem[rd_ptr];
  assign rd_side.cmd_data   = data_mem[rd_ptr];
  assign rd_side.cmd_border = border_mem[rd_ptr];

  // ==================================================
  // Storage write
  // ==================================================
  always_ff @(posedge clk_cpu) begin
    if (push) begin
      tgt_mem[wr_ptr]    <= wr_side.cmd_target;
      data_mem[wr_ptr]   <= wr_side.cmd_data;
      border_mem[wr_ptr] <= wr_side.cmd_border;
    end
  end

  // ==================================================
  // Pointers and occupancy
  // ==================================================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == fifo_ptr_t'(CMD_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == fifo_ptr_t'(CMD_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;  // Fill
        2'b01:   count <= count - 1'b1;  // Drain
        default: count <= count;         // Both or neither
      endcase
    end
  end

endmodule

/* logic/gate_array_regs.sv */
// Control registers of the machine, written by queued commands
module gate_array_regs import cpc_io_pkg::*; (
  input  logic       clk_cpu,
  input  logic       pwr_up_reset_n,
  input  logic       i_cfg_hold,        // Stall, stands in for wait/load
  io_cmd_if.dst      cmd,
  input  pen_t       i_pen_index,       // Palette read address
  output color_t     o_pen_color,
  output color_t     o_border_color,
  output logic [1:0] o_mode,
  output logic       o_lo_rom_disable,
  output logic       o_hi_rom_disable,
  output logic [2:0] o_ram_bank,
  output logic [2:0] o_ram_config,
  output byte_t      o_rom_bank,
  output byte_t      o_ppi_a,
  output byte_t      o_ppi_c,
  output scr_start_t o_scr_start
);

  logic      apply;            // Command taken this edge
  logic      border_selected;  // GA fn 0 picked the border
  pen_t      pen;              // Current pen for GA fn 1
  crtc_idx_t crtc_reg;         // Selected CRTC register
  color_t    palette [NUM_PENS];

  // ==================================================
  // Command acceptance
  // ==================================================
  assign cmd.cmd_ready = ~i_cfg_hold;
  assign apply         = cmd.cmd_valid & cmd.cmd_ready;

  // Palette lookup, no register stage
  assign o_pen_color = palette[i_pen_index];

  // ==================================================
  // Register updates
  // ==================================================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      border_selected  <= 1'b0;
      pen              <= '0;
      crtc_reg         <= '0;
      o_border_color   <= '0;
      o_mode           <= '0;
      o_lo_rom_disable <= 1'b0;
      o_hi_rom_disable <= 1'b0;
      o_ram_bank       <= '0;
      o_ram_config     <= '0;
      o_rom_bank       <= '0;
      o_ppi_a          <= '0;
      o_ppi_c          <= '0;
      o_scr_start      <= '0;
      // Palette is visible on a port, so it starts black
      for (int i = 0; i < NUM_PENS; i++)
        palette[i] <= '0;
    end else if (apply) begin
      case (cmd.cmd_target)
        ga_pen_sel: begin
          border_selected <= cmd.cmd_border;
          if (!cmd.cmd_data[4])
            pen <= cmd.cmd_data[3:0];  // Bit 4 set keeps the old pen
        end
        ga_color: begin
          if (border_selected)
            o_border_color <= cmd.cmd_data[4:0];
          else
            palette[pen] <= cmd.cmd_data[4:0];
        end
        ga_rom_mode: begin
          o_hi_rom_disable <= cmd.cmd_data[3];
          o_lo_rom_disable <= cmd.cmd_data[2];
          o_mode           <= cmd.cmd_data[1:0];
        end
        ga_ram_cfg: begin
          o_ram_bank   <= cmd.cmd_data[5:3];
          o_ram_config <= cmd.cmd_data[2:0];
        end
        rom_bank_sel: o_rom_bank <= cmd.cmd_data;
        ppi_a_wr:     o_ppi_a    <= cmd.cmd_data;  // PSG data bus
        ppi_c_wr:     o_ppi_c    <= cmd.cmd_data;  // PSG control, kbd row
        crtc_index:   crtc_reg   <= cmd.cmd_data[4:0];
        crtc_data: begin
          // Only the start address is kept
          if (crtc_reg == CRTC_REG_START_HI)
            o_scr_start[9:8] <= cmd.cmd_data[1:0];
          if (crtc_reg == CRTC_REG_START_LO)
            o_scr_start[7:0] <= cmd.cmd_data;
        end
        default: ;
      endcase
    end
  end

endmodule

/* logic/cpc_io_top.sv */
// I/O write path: decoder -> command FIFO -> register block
module cpc_io_top import cpc_io_pkg::*; (
  input  logic       clk_cpu,
  input  logic       pwr_up_reset_n,
  input  logic       i_valid,           // CPU I/O write cycle
  input  logic       i_cfg_hold,        // Stall the register block
  input  addr_t      i_addr,
  input  byte_t      i_wdata,
  output logic       o_ready,           // Cycle accepted this edge
  input  pen_t       i_pen_index,
  output color_t     o_pen_color,
  output color_t     o_border_color,
  output logic [1:0] o_mode,
  output logic       o_lo_rom_disable,
  output logic       o_hi_rom_disable,
  output logic [2:0] o_ram_bank,
  output logic [2:0] o_ram_config,
  output byte_t      o_rom_bank,
  output byte_t      o_ppi_a,
  output byte_t      o_ppi_c,
  output scr_start_t o_scr_start
);

  // ==================================================
  // Command links
  // ==================================================
  io_cmd_if dec_cmd ();  // Decoder to FIFO
  io_cmd_if reg_cmd ();  // FIFO to registers

  // ==================================================
  // Producer
  // ==================================================
  io_write_decoder u_decoder (
    .i_bus_valid (i_valid),
    .o_bus_ready (o_ready),
    .i_addr      (i_addr),
    .i_wdata     (i_wdata),
    .cmd         (dec_cmd.src)
  );

  // ==================================================
  // Buffer
  // ==================================================
  io_cmd_fifo u_fifo (
    .clk_cpu        (clk_cpu),
    .pwr_up_reset_n (pwr_up_reset_n),
    .wr_side        (dec_cmd.dst),
    .rd_side        (reg_cmd.src),
    .o_full         ()              // Ready already carries it
  );

  // ==================================================
  // Consumer
  // ==================================================
  gate_array_regs u_regs (
    .clk_cpu          (clk_cpu),
    .pwr_up_reset_n   (pwr_up_reset_n),
    .i_cfg_hold       (i_cfg_hold),
    .cmd              (reg_cmd.dst),
    .i_pen_index      (i_pen_index),
    .o_pen_color      (o_pen_color),
    .o_border_color   (o_border_color),
    .o_mode           (o_mode),
    .o_lo_rom_disable (o_lo_rom_disable),
    .o_hi_rom_disable (o_hi_rom_disable),
    .o_ram_bank       (o_ram_bank),
    .o_ram_config     (o_ram_config),
    .o_rom_bank       (o_rom_bank),
    .o_ppi_a          (o_ppi_a),
    .o_ppi_c          (o_ppi_c),
    .o_scr_start      (o_scr_start)
  );

endmodule

/* tests/tb_cpc_io_sva.sv */
// Protocol and stability checks on the I/O write top level
module tb_cpc_io_sva import cpc_io_pkg::*; (
  input logic       clk_cpu,
  input logic       pwr_up_reset_n,
  input logic       i_cfg_hold,
  input logic       o_ready,
  input fifo_ptr_t  fifo_wr_ptr,       // Queue write pointer
  input color_t     o_border_color,
  input logic [1:0] o_mode,
  input logic       o_lo_rom_disable,
  input logic       o_hi_rom_disable,
  input logic [2:0] o_ram_bank,
  input logic [2:0] o_ram_config,
  input byte_t      o_rom_bank,
  input byte_t      o_ppi_a,
  input byte_t      o_ppi_c,
  input scr_start_t o_scr_start
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;  // Read back by the testbench

  // ==================================================
  // Bus handshake
  // ==================================================
  // Stalled bus, the queue write pointer must not move
  assert property (@(posedge clk_cpu) disable iff (!pwr_up_reset_n)
    !o_ready |=> $stable(fifo_wr_ptr))
    else begin
      fail_count++;
      $error("Command pushed while o_ready low");
    end

  // Empty queue straight out of reset
  assert property (@(posedge clk_cpu) !pwr_up_reset_n |=> o_ready)
    else begin
      fail_count++;
      $error("o_ready not high one cycle after reset");
    end

  // ==================================================
  // Register stability under hold
  // ==================================================
  assert property (@(posedge clk_cpu) disable iff (!pwr_up_reset_n)
    i_cfg_hold |=> $stable({o_border_color, o_mode, o_lo_rom_disable, o_hi_rom_disable,
                            o_ram_bank, o_ram_config, o_rom_bank, o_ppi_a, o_ppi_c,
                            o_scr_start}))
    else begin
      fail_count++;
      $error("Register output changed while i_cfg_hold high");
    end

endmodule

bind cpc_io_top tb_cpc_io_sva u_sva (
  .clk_cpu          (clk_cpu),
  .pwr_up_reset_n   (pwr_up_reset_n),
  .i_cfg_hold       (i_cfg_hold),
  .o_ready          (o_ready),
  .fifo_wr_ptr      (u_fifo.wr_ptr),
  .o_border_color   (o_border_color),
  .o_mode           (o_mode),
  .o_lo_rom_disable (o_lo_rom_disable),
  .o_hi_rom_disable (o_hi_rom_disable),
  .o_ram_bank       (o_ram_bank),
  .o_ram_config     (o_ram_config),
  .o_rom_bank       (o_rom_bank),
  .o_ppi_a          (o_ppi_a),
  .o_ppi_c          (o_ppi_c),
  .o_scr_start      (o_scr_start)
);

/* tests/tb_cpc_io.sv */
// Testbench for the I/O write path, table driven with a reference model
module tb_cpc_io import cpc_io_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // ==================================================
  // Constants and stimulus table
  // ==================================================
  localparam int RESET_CYCLES  = 16;
  localparam int SETTLE_CYCLES = 8;
  localparam int NUM_ROWS      = 18;

  // Output watched by a table row
  localparam logic [3:0] W_PEN = 4'd1, W_BORDER = 4'd2;
  localparam logic [3:0] W_MODE = 4'd3, W_RAM = 4'd4, W_ROM = 4'd5;
  localparam logic [3:0] W_PPI_A = 4'd6, W_PPI_C = 4'd7, W_SCR = 4'd8;

  typedef struct packed {
    addr_t       addr;
    byte_t       data;
    logic [3:0]  sel;   // Which output to watch
    logic [15:0] exp;   // Hand-derived value of it
  } row_t;

  localparam row_t ROWS [NUM_ROWS] = '{
    '{16'h7f00, 8'h04, W_PEN,    16'h0000},  // Pen 4
    '{16'h7f00, 8'h55, W_PEN,    16'h0015},  // Ink 4 = 0x15
    '{16'h7f10, 8'h10, W_PEN,    16'h0015},  // Border select, pen kept
    '{16'h7f00, 8'h4b, W_BORDER, 16'h000b},
    '{16'h7f00, 8'h8d, W_MODE,   16'h000d},  // Both ROMs off, mode 1
    '{16'h7f00, 8'hd6, W_RAM,    16'h0016},  // Bank 2, config 6
    '{16'hdf00, 8'h07, W_ROM,    16'h0007},
    '{16'hf400, 8'ha5, W_PPI_A,  16'h00a5},
    '{16'hf600, 8'h3c, W_PPI_C,  16'h003c},
    '{16'hfa00, 8'h99, W_PPI_C,  16'h003c},  // No decode, port C untouched
    '{16'hbc00, 8'h0c, W_SCR,    16'h0000},  // Select R12
    '{16'hbd00, 8'h03, W_SCR,    16'h0300},
    '{16'hbc00, 8'h0d, W_SCR,    16'h0300},  // Select R13
    '{16'hbd00, 8'h5a, W_SCR,    16'h035a},
    '{16'hbc00, 8'h05, W_SCR,    16'h035a},  // Some other register
    '{16'hbd00, 8'hff, W_SCR,    16'h035a},  // Ignored
    '{16'h7f00, 8'h02, W_PEN,    16'h0000},  // Pen 2, border off
    '{16'h4000, 8'h5e, W_PEN,    16'h001e}   // Other GA address
  };

  // Five queued GA writes, last colour to pen 5 wins
  localparam byte_t HOLD_DATA [5] = '{8'h03, 8'h4a, 8'h05, 8'h4c, 8'h4d};

  string sel_names [9] = '{"none", "o_pen_color", "o_border_color", "mode_rom",
                           "ram_bank_config", "o_rom_bank", "o_ppi_a", "o_ppi_c",
                           "o_scr_start"};

  // ==================================================
  // DUT signals and instance
  // ==================================================
  logic       clk_cpu, pwr_up_reset_n, i_valid, i_cfg_hold, o_ready;
  addr_t      i_addr;
  byte_t      i_wdata, o_rom_bank, o_ppi_a, o_ppi_c;
  pen_t       i_pen_index;
  color_t     o_pen_color, o_border_color;
  logic [1:0] o_mode;
  logic       o_lo_rom_disable, o_hi_rom_disable;
  logic [2:0] o_ram_bank, o_ram_config;
  scr_start_t o_scr_start;

  int errors = 0;
  int checks = 0;

  // Reference model state
  logic       m_border_sel, m_hi, m_lo;
  pen_t       m_pen;
  color_t     m_border;
  color_t     m_palette [16];
  logic [1:0] m_mode;
  logic [2:0] m_bank, m_cfg;
  byte_t      m_rom, m_ppi_a, m_ppi_c;
  logic [4:0] m_crtc;
  scr_start_t m_scr;

  cpc_io_top uut (.*);

  always #50 clk_cpu = ~clk_cpu;  // 100 ns period

  // ==================================================
  // Helpers
  // ==================================================
  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  // Mirror of the register rules, decode done from scratch
  task automatic model_write(input addr_t addr, input byte_t data);
    if (addr[15:14] == 2'b01) begin
      case (data[7:6])
        2'd0: begin
          m_border_sel = addr[4];
          if (!data[4])
            m_pen = data[3:0];
        end
        2'd1: begin
          if (m_border_sel)
            m_border = data[4:0];
          else
            m_palette[m_pen] = data[4:0];
        end
        2'd2: begin
          m_hi   = data[3];
          m_lo   = data[2];
          m_mode = data[1:0];
        end
        default: begin
          m_bank = data[5:3];
          m_cfg  = data[2:0];
        end
      endcase
    end else if (!addr[13]) begin
      m_rom = data;
    end else begin
      case (addr[15:8])
        8'hf4: m_ppi_a = data;
        8'hf6: m_ppi_c = data;
        8'hbc: m_crtc  = data[4:0];
        8'hbd: begin
          if (m_crtc == 5'd12)
            m_scr[9:8] = data[1:0];
          if (m_crtc == 5'd13)
            m_scr[7:0] = data;
        end
        default: ;  // Swallowed
      endcase
    end
  endtask

  function automatic logic [15:0] watched_value(input logic [3:0] sel);
    case (sel)
      W_PEN:    return 16'(o_pen_color);
      W_BORDER: return 16'(o_border_color);
      W_MODE:   return 16'({o_hi_rom_disable, o_lo_rom_disable, o_mode});
      W_RAM:    return 16'({o_ram_bank, o_ram_config});
      W_ROM:    return 16'(o_rom_bank);
      W_PPI_A:  return 16'(o_ppi_a);
      W_PPI_C:  return 16'(o_ppi_c);
      W_SCR:    return 16'(o_scr_start);
      default:  return 16'h0000;
    endcase
  endfunction

  // One bus cycle, waits out any stall
  task automatic send_write(input addr_t addr, input byte_t data);
    @(negedge clk_cpu);
    i_valid = 1'b1;
    i_addr  = addr;
    i_wdata = data;
    while (!o_ready)
      @(negedge clk_cpu);
    @(negedge clk_cpu);  // Accepted on the edge just passed
    i_valid = 1'b0;
  endtask

  // Full snapshot, palette read at the current pen
  task automatic check_all();
    @(negedge clk_cpu);
    i_pen_index = m_pen;
    @(negedge clk_cpu);
    compare("o_pen_color", o_pen_color, m_palette[m_pen]);
    compare("o_border_color", o_border_color, m_border);
    compare("o_mode", o_mode, m_mode);
    compare("o_hi_rom_disable", o_hi_rom_disable, m_hi);
    compare("o_lo_rom_disable", o_lo_rom_disable, m_lo);
    compare("o_ram_bank", o_ram_bank, m_bank);
    compare("o_ram_config", o_ram_config, m_cfg);
    compare("o_rom_bank", o_rom_bank, m_rom);
    compare("o_ppi_a", o_ppi_a, m_ppi_a);
    compare("o_ppi_c", o_ppi_c, m_ppi_c);
    compare("o_scr_start", o_scr_start, m_scr);
  endtask

  task automatic check_palette();
    for (int p = 0; p < 16; p++) begin
      i_pen_index = pen_t'(p);
      @(negedge clk_cpu);
      compare($sformatf("o_pen_color[%0d]", p), o_pen_color, m_palette[p]);
    end
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    clk_cpu        = 1'b0;
    pwr_up_reset_n = 1'b0;
    i_valid        = 1'b0;
    i_cfg_hold     = 1'b0;
    i_addr         = '0;
    i_wdata        = '0;
    i_pen_index    = '0;
    void'($urandom(32'he8a8));
    {m_border_sel, m_hi, m_lo, m_pen, m_border, m_mode} = '0;
    {m_bank, m_cfg, m_rom, m_ppi_a, m_ppi_c, m_crtc, m_scr} = '0;
    for (int p = 0; p < 16; p++)
      m_palette[p] = '0;
    repeat (RESET_CYCLES) @(negedge clk_cpu);
    pwr_up_reset_n = 1'b1;

    // Everything zero out of reset
    compare("o_ready", o_ready, 1'b1);
    check_all();
    check_palette();

    for (int r = 0; r < NUM_ROWS; r++) begin
      repeat ($urandom_range(0, 2)) @(negedge clk_cpu);  // Idle gap
      i_cfg_hold = ($urandom_range(0, 1) == 1);
      send_write(ROWS[r].addr, ROWS[r].data);
      repeat ($urandom_range(0, 3)) @(negedge clk_cpu);  // Hold stretch
      i_cfg_hold = 1'b0;
      model_write(ROWS[r].addr, ROWS[r].data);
      repeat (SETTLE_CYCLES) @(negedge clk_cpu);
      check_all();
      compare(sel_names[ROWS[r].sel], watched_value(ROWS[r].sel), ROWS[r].exp);
    end

    // ==================================================
    // Back-pressure, queue fills to four
    // ==================================================
    @(negedge clk_cpu);
    i_cfg_hold = 1'b1;
    for (int k = 0; k < 4; k++) begin
      compare("o_ready", o_ready, 1'b1);
      send_write(16'h7f00, HOLD_DATA[k]);
    end
    @(negedge clk_cpu);
    i_valid = 1'b1;  // Fifth cycle must stall
    i_wdata = HOLD_DATA[4];
    compare("o_ready", o_ready, 1'b0);
    check_all();     // Nothing applied yet
    i_cfg_hold = 1'b0;
    while (!o_ready)
      @(negedge clk_cpu);
    @(negedge clk_cpu);
    i_valid = 1'b0;
    for (int k = 0; k < 5; k++)
      model_write(16'h7f00, HOLD_DATA[k]);
    repeat (SETTLE_CYCLES) @(negedge clk_cpu);
    check_all();
    check_palette();

    errors += uut.u_sva.fail_count;
    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // Watchdog, sized from the table
  initial begin
    repeat (NUM_ROWS * 40 + RESET_CYCLES) @(posedge clk_cpu);
    $display("Timeout: sequence did not finish, %0d errors so far", errors);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* files.f */
logic/cpc_io_pkg.sv
logic/io_cmd_if.sv
logic/io_write_decoder.sv
logic/io_cmd_fifo.sv
logic/gate_array_regs.sv
logic/cpc_io_top.sv
tests/tb_cpc_io_sva.sv
tests/tb_cpc_io.sv
